// ==== source/simd_pkg.sv ====
// Shared types and element helpers for one 64-bit lane of the vector unit
// Helpers assume idx < 64/SEW; higher indices give undefined shifts
package simd_pkg;

    localparam int DATA_W = 64;

    typedef logic [DATA_W-1:0] bus64_t;

    typedef enum logic [1:0] {
        SEW_8, SEW_16, SEW_32, SEW_64
    } sew_e;

    typedef enum logic [4:0] {
        VNOP,
        VADD, VSUB, VRSUB,
        VMIN, VMINU, VMAX, VMAXU,
        VMSEQ, VMSLT, VMSLTU, VMSLE, VMSLEU,
        VSLL, VSRL, VSRA,
        VMUL, VMULH, VMULHU,
        VAND, VOR, VXOR,
        VID, VMV, VMERGE
    } vop_e;

    typedef enum logic [2:0] {
        U_ADDSUB, U_COMP, U_SHIFT, U_MUL, U_LOGIC, U_ID, U_MOVE, U_NONE
    } unit_e;

    typedef struct packed {
        vop_e op;
        sew_e sew;
    } lane_instr_t;

    typedef struct packed {
        logic  valid;
        vop_e  op;
        sew_e  sew;
        unit_e unit;
    } lane_ctrl_t;

    // Element idx of word, sign or zero extended by one bit
    function automatic logic [DATA_W:0] elem_get(bus64_t word, int unsigned idx, sew_e sew,
                                                 logic sgn);
        int unsigned w;
        bus64_t      top;
        bus64_t      val;
        w   = 8 << sew;
        top = word << (DATA_W - (idx + 1) * w);  // Element moved to the MSBs
        if (sgn) begin
            val = bus64_t'($signed(top) >>> (DATA_W - w));
        end else begin
            val = top >> (DATA_W - w);
        end
        return {sgn & top[DATA_W-1], val};
    endfunction

    // ORs the low SEW bits of val into element idx of word
    function automatic bus64_t elem_put(bus64_t word, int unsigned idx, sew_e sew, bus64_t val);
        int unsigned w;
        bus64_t      mask;
        w    = 8 << sew;
        mask = {DATA_W{1'b1}} >> (DATA_W - w);
        return word | ((val & mask) << (idx * w));
    endfunction

endpackage

// ==== source/lane_ctrl.sv ====
// Decode and two-stage control pipeline of the lane
// Only the valid bits are reset; the other control fields follow them
`timescale 1ns/1ps

module lane_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  simd_pkg::lane_instr_t instr_i,
    output simd_pkg::lane_ctrl_t  issue_ctrl_o,
    output simd_pkg::lane_ctrl_t  s1_ctrl_o,
    output simd_pkg::lane_ctrl_t  s2_ctrl_o
);
    import simd_pkg::*;

    unit_e      unit;
    lane_ctrl_t s1_q;
    lane_ctrl_t s2_q;

    // Opcode to result class
    always_comb begin
        case (instr_i.op)
            VADD, VSUB, VRSUB: unit = U_ADDSUB;
            VMIN, VMINU, VMAX, VMAXU,
            VMSEQ, VMSLT, VMSLTU, VMSLE, VMSLEU: unit = U_COMP;
            VSLL, VSRL, VSRA: unit = U_SHIFT;
            VMUL, VMULH, VMULHU: unit = U_MUL;
            VAND, VOR, VXOR: unit = U_LOGIC;
            VID: unit = U_ID;
            VMV, VMERGE: unit = U_MOVE;
            default: unit = U_NONE;  // VNOP and unused codes
        endcase
    end

    assign issue_ctrl_o = '{valid: valid_i, op: instr_i.op, sew: instr_i.sew, unit: unit};

    always_ff @(posedge clk_i) begin
        s1_q <= issue_ctrl_o;
        s2_q <= s1_q;
        if (!rst_n_i) begin
            s1_q.valid <= 1'b0;  // Kills anything in flight
            s2_q.valid <= 1'b0;
        end
    end

    assign s1_ctrl_o = s1_q;
    assign s2_ctrl_o = s2_q;

endmodule

// ==== source/vaddsub.sv ====
// Packed add, subtract and reverse subtract, wrapping per element
// Byte adders chain carries only inside one element
`timescale 1ns/1ps

module vaddsub (
    input  simd_pkg::vop_e   op_i,
    input  simd_pkg::sew_e   sew_i,
    input  simd_pkg::bus64_t data_vs1_i,
    input  simd_pkg::bus64_t data_vs2_i,
    output simd_pkg::bus64_t data_vd_o
);
    import simd_pkg::*;

    bus64_t     opa;
    bus64_t     opb;
    logic       sub;
    logic [2:0] byte_mask;
    logic [8:0] carry;
    logic       cin;

    always_comb begin
        case (op_i)
            VSUB:    {opa, opb} = {data_vs2_i, ~data_vs1_i};  // vs2 - vs1
            VRSUB:   {opa, opb} = {data_vs1_i, ~data_vs2_i};  // vs1 - vs2
            default: {opa, opb} = {data_vs2_i, data_vs1_i};
        endcase
        sub       = (op_i == VSUB) || (op_i == VRSUB);
        byte_mask = 3'((4'd1 << sew_i) - 4'd1);  // Bytes per element minus one
        carry     = '0;
        data_vd_o = '0;
        for (int b = 0; b < DATA_W / 8; b++) begin
            // First byte of an element takes the +1 of a subtract
            if ((3'(b) & byte_mask) == 3'd0) begin
                cin = sub;
            end else begin
                cin = carry[b];
            end
            {carry[b+1], data_vd_o[b*8 +: 8]} = opa[b*8 +: 8] + opb[b*8 +: 8] + cin;
        end
    end

endmodule

// ==== source/vcomp.sv ====
// Per-element min/max and mask-producing compares
// Compare results are packed from bit 0, one bit per element, upper bits zero
`timescale 1ns/1ps

module vcomp (
    input  simd_pkg::vop_e   op_i,
    input  simd_pkg::sew_e   sew_i,
    input  simd_pkg::bus64_t data_vs1_i,
    input  simd_pkg::bus64_t data_vs2_i,
    output simd_pkg::bus64_t data_vd_o
);
    import simd_pkg::*;

    logic            sgn;
    logic            is_mask;
    logic [DATA_W:0] a;
    logic [DATA_W:0] b;
    logic            lt;
    logic            eq;
    bus64_t          minmax;
    logic [7:0]      mask;

    always_comb begin
        sgn     = (op_i == VMIN) || (op_i == VMAX) || (op_i == VMSLT) || (op_i == VMSLE);
        is_mask = (op_i == VMSEQ) || (op_i == VMSLT) || (op_i == VMSLTU) ||
                  (op_i == VMSLE) || (op_i == VMSLEU);
        a       = '0;
        b       = '0;
        lt      = 1'b0;
        eq      = 1'b0;
        minmax  = '0;
        mask    = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < (8 >> sew_i)) begin
                a  = elem_get(data_vs2_i, i, sew_i, sgn);
                b  = elem_get(data_vs1_i, i, sew_i, sgn);
                lt = $signed(a) < $signed(b);  // Extension bit makes unsigned safe
                eq = (a == b);
                case (op_i)
                    VMIN, VMINU: minmax = elem_put(minmax, i, sew_i,
                                                   lt ? a[DATA_W-1:0] : b[DATA_W-1:0]);
                    VMAX, VMAXU: minmax = elem_put(minmax, i, sew_i,
                                                   lt ? b[DATA_W-1:0] : a[DATA_W-1:0]);
                    VMSEQ:          mask[i] = eq;
                    VMSLT, VMSLTU:  mask[i] = lt;
                    VMSLE, VMSLEU:  mask[i] = lt | eq;
                    default:        mask[i] = 1'b0;
                endcase
            end
        end
        if (is_mask) begin
            data_vd_o = {{(DATA_W - 8){1'b0}}, mask};
        end else begin
            data_vd_o = minmax;
        end
    end

endmodule

// ==== source/vshift.sv ====
// Per-element shifts of vs2 by the low log2(SEW) bits of the vs1 element
`timescale 1ns/1ps

module vshift (
    input  simd_pkg::vop_e   op_i,
    input  simd_pkg::sew_e   sew_i,
    input  simd_pkg::bus64_t data_vs1_i,
    input  simd_pkg::bus64_t data_vs2_i,
    output simd_pkg::bus64_t data_vd_o
);
    import simd_pkg::*;

    logic [DATA_W:0] a;
    logic [DATA_W:0] s;
    logic [5:0]      amt;
    logic [5:0]      amt_mask;
    bus64_t          res;

    always_comb begin
        amt_mask  = 6'((7'd8 << sew_i) - 7'd1);  // SEW - 1
        a         = '0;
        s         = '0;
        amt       = '0;
        res       = '0;
        data_vd_o = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < (8 >> sew_i)) begin
                a   = elem_get(data_vs2_i, i, sew_i, op_i == VSRA);  // Sign fill for VSRA
                s   = elem_get(data_vs1_i, i, sew_i, 1'b0);
                amt = s[5:0] & amt_mask;
                case (op_i)
                    VSLL:       res = a[DATA_W-1:0] << amt;
                    VSRL, VSRA: res = bus64_t'($signed(a) >>> amt);
                    default:    res = '0;
                endcase
                data_vd_o = elem_put(data_vd_o, i, sew_i, res);
            end
        end
    end

endmodule

// ==== source/vmul.sv ====
// Two-stage packed multiplier; stage 1 holds double-width products
// Stage 2 picks low half (VMUL) or high half (VMULH, VMULHU) per element
`timescale 1ns/1ps

module vmul (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  simd_pkg::vop_e       op_i,
    input  simd_pkg::sew_e       sew_i,
    input  simd_pkg::bus64_t     data_vs1_i,
    input  simd_pkg::bus64_t     data_vs2_i,
    input  simd_pkg::lane_ctrl_t s1_ctrl_i,
    output simd_pkg::bus64_t     data_vd_o
);
    import simd_pkg::*;

    logic [DATA_W:0]       a;
    logic [DATA_W:0]       b;
    logic [2*DATA_W+1:0]   p;
    logic [2*DATA_W-1:0]   pmask;
    logic [2*DATA_W-1:0]   prod_d;
    logic [2*DATA_W-1:0]   prod_q;
    logic [2*DATA_W-1:0]   full;
    bus64_t                res_d;
    bus64_t                res_q;
    int unsigned           w1;
    int unsigned           w2;

    // Stage 1, products at the issue width
    always_comb begin
        w1     = 8 << sew_i;
        pmask  = {(2 * DATA_W){1'b1}} >> (2 * DATA_W - 2 * w1);
        a      = '0;
        b      = '0;
        p      = '0;
        prod_d = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < (8 >> sew_i)) begin
                a      = elem_get(data_vs2_i, i, sew_i, op_i == VMULH);
                b      = elem_get(data_vs1_i, i, sew_i, op_i == VMULH);
                p      = $signed(a) * $signed(b);
                prod_d = prod_d | ((p[2*DATA_W-1:0] & pmask) << (i * 2 * w1));
            end
        end
    end

    always_ff @(posedge clk_i) begin
        prod_q <= prod_d;
    end

    // Stage 2, half select with the stage-1 opcode and width
    always_comb begin
        w2    = 8 << s1_ctrl_i.sew;
        full  = '0;
        res_d = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < (8 >> s1_ctrl_i.sew)) begin
                full = prod_q >> (i * 2 * w2);
                if (s1_ctrl_i.op != VMUL) begin
                    full = full >> w2;  // High half
                end
                res_d = elem_put(res_d, i, s1_ctrl_i.sew, full[DATA_W-1:0]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_q <= '0;
        end else if (s1_ctrl_i.valid && (s1_ctrl_i.unit == U_MUL)) begin
            res_q <= res_d;
        end
    end

    assign data_vd_o = res_q;

endmodule

// ==== source/functional_unit.sv ====
// Early-result datapath of the lane, aligned to the multiplier latency
// VID uses LANE_ID, so each lane instance needs its own value
`timescale 1ns/1ps

module functional_unit #(
    parameter int LANE_ID = 0
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  simd_pkg::lane_ctrl_t issue_ctrl_i,
    input  simd_pkg::lane_ctrl_t s2_ctrl_i,
    input  simd_pkg::bus64_t     data_vs1_i,
    input  simd_pkg::bus64_t     data_vs2_i,
    input  simd_pkg::bus64_t     mul_result_i,
    output logic                 valid_o,
    output simd_pkg::bus64_t     data_vd_o
);
    import simd_pkg::*;

    bus64_t res_addsub;
    bus64_t res_comp;
    bus64_t res_shift;
    bus64_t res_id;
    bus64_t early_d;
    bus64_t early_q1;
    bus64_t early_q2;

    vaddsub vaddsub_inst (
        .op_i       (issue_ctrl_i.op),
        .sew_i      (issue_ctrl_i.sew),
        .data_vs1_i (data_vs1_i),
        .data_vs2_i (data_vs2_i),
        .data_vd_o  (res_addsub)
    );

    vcomp vcomp_inst (
        .op_i       (issue_ctrl_i.op),
        .sew_i      (issue_ctrl_i.sew),
        .data_vs1_i (data_vs1_i),
        .data_vs2_i (data_vs2_i),
        .data_vd_o  (res_comp)
    );

    vshift vshift_inst (
        .op_i       (issue_ctrl_i.op),
        .sew_i      (issue_ctrl_i.sew),
        .data_vs1_i (data_vs1_i),
        .data_vs2_i (data_vs2_i),
        .data_vd_o  (res_shift)
    );

    // Element i holds LANE_ID * (64/SEW) + i
    always_comb begin
        res_id = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < (8 >> issue_ctrl_i.sew)) begin
                res_id = elem_put(res_id, i, issue_ctrl_i.sew,
                                  bus64_t'(LANE_ID * (8 >> issue_ctrl_i.sew) + i));
            end
        end
    end

    always_comb begin
        case (issue_ctrl_i.unit)
            U_ADDSUB: early_d = res_addsub;
            U_COMP:   early_d = res_comp;
            U_SHIFT:  early_d = res_shift;
            U_LOGIC: begin
                case (issue_ctrl_i.op)
                    VAND:    early_d = data_vs1_i & data_vs2_i;
                    VOR:     early_d = data_vs1_i | data_vs2_i;
                    default: early_d = data_vs1_i ^ data_vs2_i;
                endcase
            end
            U_ID:     early_d = res_id;
            U_MOVE:   early_d = data_vs1_i;  // VMV and VMERGE
            default:  early_d = '0;          // Multiplies come from vmul
        endcase
    end

    // Two-stage alignment to match vmul
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            early_q1 <= '0;
            early_q2 <= '0;
        end else begin
            if (issue_ctrl_i.valid) begin
                early_q1 <= early_d;
            end
            early_q2 <= early_q1;
        end
    end

    assign valid_o   = s2_ctrl_i.valid;
    assign data_vd_o = (s2_ctrl_i.unit == U_MUL) ? mul_result_i : early_q2;

endmodule

// ==== source/simd_lane_top.sv ====
// One lane of the SIMD execution unit, fixed 2-cycle latency, no back-pressure
// Set LANE_ID to the lane's position in the vector register
`timescale 1ns/1ps

module simd_lane_top #(
    parameter int LANE_ID = 0
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  simd_pkg::lane_instr_t instr_i,
    input  simd_pkg::bus64_t      data_vs1_i,
    input  simd_pkg::bus64_t      data_vs2_i,
    output logic                  valid_o,
    output simd_pkg::bus64_t      data_vd_o
);
    import simd_pkg::*;

    lane_ctrl_t issue_ctrl;
    lane_ctrl_t s1_ctrl;
    lane_ctrl_t s2_ctrl;
    bus64_t     mul_result;

    lane_ctrl lane_ctrl_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .issue_ctrl_o (issue_ctrl),
        .s1_ctrl_o    (s1_ctrl),
        .s2_ctrl_o    (s2_ctrl)
    );

    vmul vmul_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .op_i       (issue_ctrl.op),
        .sew_i      (issue_ctrl.sew),
        .data_vs1_i (data_vs1_i),
        .data_vs2_i (data_vs2_i),
        .s1_ctrl_i  (s1_ctrl),
        .data_vd_o  (mul_result)
    );

    functional_unit #(
        .LANE_ID (LANE_ID)
    ) functional_unit_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .issue_ctrl_i (issue_ctrl),
        .s2_ctrl_i    (s2_ctrl),
        .data_vs1_i   (data_vs1_i),
        .data_vs2_i   (data_vs2_i),
        .mul_result_i (mul_result),
        .valid_o      (valid_o),
        .data_vd_o    (data_vd_o)
    );

endmodule

// ==== verification/simd_lane_asserts.sv ====
// Protocol checks bound into simd_lane_top
// Timing checks assume the fixed two-cycle latency and no back-pressure
`timescale 1ns/1ps

module simd_lane_asserts (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             valid_i,
    input logic             out_valid_i,
    input simd_pkg::bus64_t out_data_i
);
    int failures = 0;  // Assertion hits

    // Quiet through reset and the two refill cycles
    reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !out_valid_i ##1 !out_valid_i)
        else begin
            $error("valid_o high during reset or in the two cycles after it");
            failures++;
        end

    issue_to_output: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> ##2 out_valid_i)
        else begin
            $error("issued instruction gave no valid_o two cycles later");
            failures++;
        end

    output_from_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i |-> $past(valid_i, 2))
        else begin
            $error("valid_o without an issue two cycles earlier");
            failures++;
        end

    data_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i |-> !$isunknown(out_data_i))
        else begin
            $error("data_vd_o has unknown bits while valid_o is high");
            failures++;
        end

endmodule

// ==== verification/simd_lane_checker.sv ====
// Reference model and scoreboard for one lane, results expected in issue order
// Queue is flushed whenever reset is sampled low
`timescale 1ns/1ps

module simd_lane_checker #(
    parameter int LANE_ID = 0
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  simd_pkg::lane_instr_t instr_i,
    input  simd_pkg::bus64_t      data_vs1_i,
    input  simd_pkg::bus64_t      data_vs2_i,
    input  logic                  dut_valid_i,
    input  simd_pkg::bus64_t      dut_data_i,
    output int                    checks_o,
    output int                    errors_o,
    output int                    pending_o
);
    import simd_pkg::*;

    typedef struct packed {
        vop_e   op;
        sew_e   sew;
        bus64_t data;
    } expect_t;

    expect_t exp_q[$];
    expect_t head;

    function automatic bus64_t model(vop_e op, sew_e sew, bus64_t vs1, bus64_t vs2);
        int unsigned         w;
        bus64_t              mask;
        bus64_t              a;
        bus64_t              b;
        bus64_t              r;
        bus64_t              res;
        logic [127:0]        ua;
        logic [127:0]        ub;
        logic signed [127:0] sa;
        logic signed [127:0] sb;
        w    = 8 << sew;
        mask = {64{1'b1}} >> (64 - w);
        res  = '0;
        for (int i = 0; i < 64 / w; i++) begin
            a  = (vs2 >> (i * w)) & mask;  // vs2 element
            b  = (vs1 >> (i * w)) & mask;  // vs1 element
            ua = {64'd0, a};
            ub = {64'd0, b};
            sa = a[w-1] ? $signed(ua - (128'd1 << w)) : $signed(ua);
            sb = b[w-1] ? $signed(ub - (128'd1 << w)) : $signed(ub);
            case (op)
                VADD:        r = a + b;
                VSUB:        r = a - b;
                VRSUB:       r = b - a;
                VMIN:        r = (sa < sb) ? a : b;
                VMINU:       r = (a < b) ? a : b;
                VMAX:        r = (sa > sb) ? a : b;
                VMAXU:       r = (a > b) ? a : b;
                VMSEQ:       r = 64'(a == b);
                VMSLT:       r = 64'(sa < sb);
                VMSLTU:      r = 64'(a < b);
                VMSLE:       r = 64'(sa <= sb);
                VMSLEU:      r = 64'(a <= b);
                VSLL:        r = a << (b % w);
                VSRL:        r = a >> (b % w);
                VSRA:        r = 64'(sa >>> (b % w));
                VMUL:        r = 64'(ua * ub);
                VMULH:       r = 64'((sa * sb) >>> w);
                VMULHU:      r = 64'((ua * ub) >> w);
                VAND:        r = a & b;
                VOR:         r = a | b;
                VXOR:        r = a ^ b;
                VID:         r = 64'(LANE_ID * (64 / w) + i);
                VMV, VMERGE: r = b;
                default:     r = '0;
            endcase
            if (op inside {VMSEQ, VMSLT, VMSLTU, VMSLE, VMSLEU}) begin
                res[i] = r[0];  // One mask bit per element
            end else begin
                res = res | ((r & mask) << (i * w));
            end
        end
        return res;
    endfunction

    always @(posedge clk_i) begin
        if (dut_valid_i) begin
            if (exp_q.size() == 0) begin
                $display("error at %0t: valid_o high with no instruction outstanding", $time);
                errors_o++;
            end else begin
                head = exp_q.pop_front();
                checks_o++;
                if (dut_data_i !== head.data) begin
                    $display("mismatch at %0t: %s sew %0d expected %h got %h", $time,
                             head.op.name(), 8 << head.sew, head.data, dut_data_i);
                    errors_o++;
                end
            end
        end
        if (!rst_n_i) begin
            exp_q.delete();  // Work in flight is dropped by reset
        end else if (valid_i) begin
            exp_q.push_back('{op: instr_i.op, sew: instr_i.sew,
                              data: model(instr_i.op, instr_i.sew, data_vs1_i, data_vs2_i)});
        end
        pending_o = exp_q.size();
    end

endmodule

// ==== verification/simd_lane_tb.sv ====
// Random test of one lane at LANE_ID 3, seed 83, inputs driven 1 ns after the clock edge
// Run length is bounded by a cycle limit derived from the test sizes
`timescale 1ns/1ps

module simd_lane_tb;
    import simd_pkg::*;

    localparam int LANE_ID     = 3;
    localparam int RST_CYCLES  = 3;
    localparam int N_ARITH     = 200;
    localparam int N_OTHER     = 150;  // Compare, shift, multiply and gap tests
    localparam int N_LOGIC     = 100;
    localparam int MAX_GAP     = 3;
    localparam int TOTAL_ISSUE = N_ARITH + 4 * N_OTHER + N_LOGIC;
    localparam int CYCLE_LIMIT = TOTAL_ISSUE + N_OTHER * MAX_GAP + 2 * RST_CYCLES + 6 * 4 + 50;

    logic        clk_i;
    logic        rst_n_i;
    logic        valid_i;
    lane_instr_t instr_i;
    bus64_t      data_vs1_i;
    bus64_t      data_vs2_i;
    logic        valid_o;
    bus64_t      data_vd_o;
    int          checks;
    int          errors;
    int          pending;
    int          cycles = 0;
    int          failed;

    simd_lane_top #(
        .LANE_ID (LANE_ID)
    ) simd_lane_top_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .instr_i    (instr_i),
        .data_vs1_i (data_vs1_i),
        .data_vs2_i (data_vs2_i),
        .valid_o    (valid_o),
        .data_vd_o  (data_vd_o)
    );

    simd_lane_checker #(
        .LANE_ID (LANE_ID)
    ) simd_lane_checker_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .data_vs1_i  (data_vs1_i),
        .data_vs2_i  (data_vs2_i),
        .dut_valid_i (valid_o),
        .dut_data_i  (data_vd_o),
        .checks_o    (checks),
        .errors_o    (errors),
        .pending_o   (pending)
    );

    bind simd_lane_top simd_lane_asserts simd_lane_asserts_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .out_valid_i (valid_o),
        .out_data_i  (data_vd_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: no result after %0d cycles, %0d still outstanding",
                     CYCLE_LIMIT, pending);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Mix of overflow corners and plain random words
    function automatic bus64_t rand_word();
        case ($urandom_range(7, 0))
            0:       return {64{1'b1}};
            1:       return {8{8'h80}};
            2:       return {8{8'h7F}};
            default: return {$urandom, $urandom};
        endcase
    endfunction

    // All ones over a random subset of elements
    function automatic bus64_t elem_mask(sew_e sew);
        int unsigned w;
        bus64_t      m;
        w = 8 << sew;
        m = '0;
        for (int i = 0; i < 64 / w; i++) begin
            if ($urandom_range(1, 0) == 1) begin
                m = m | (({64{1'b1}} >> (64 - w)) << (i * w));
            end
        end
        return m;
    endfunction

    function automatic bus64_t sign_bits(sew_e sew);
        case (sew)
            SEW_8:   return {8{8'h80}};
            SEW_16:  return {4{16'h8000}};
            SEW_32:  return {2{32'h8000_0000}};
            default: return 64'h8000_0000_0000_0000;
        endcase
    endfunction

    // Random upper bits, amount per element is 0, SEW-1 or random
    function automatic bus64_t shift_amounts(sew_e sew);
        int unsigned w;
        bus64_t      word;
        bus64_t      amt;
        w    = 8 << sew;
        word = {$urandom, $urandom};
        for (int i = 0; i < 64 / w; i++) begin
            case ($urandom_range(2, 0))
                0:       amt = 0;
                1:       amt = w - 1;
                default: amt = $urandom_range(w - 1, 0);
            endcase
            word = (word & ~(bus64_t'(w - 1) << (i * w))) | (amt << (i * w));
        end
        return word;
    endfunction

    task automatic drive(vop_e op, sew_e sew, bus64_t vs1, bus64_t vs2);
        @(posedge clk_i);
        #1;
        valid_i    = 1'b1;
        instr_i    = '{op: op, sew: sew};
        data_vs1_i = vs1;
        data_vs2_i = vs2;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
            valid_i = 1'b0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        rst_n_i = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
    endtask

    task automatic issue_one(int id);
        vop_e   op;
        sew_e   sew;
        bus64_t vs1;
        bus64_t vs2;
        bus64_t sel;
        int     idx;
        sew = sew_e'($urandom_range(3, 0));
        vs1 = rand_word();
        vs2 = rand_word();
        sel = elem_mask(sew);
        case (id)
            0: op = vop_e'($urandom_range(VRSUB, VADD));
            1: begin
                op  = vop_e'($urandom_range(VMSLEU, VMIN));
                vs1 = (vs2 & sel) | (vs1 & ~sel);  // Equal where sel is set
            end
            2: begin
                op  = vop_e'($urandom_range(VSRA, VSLL));
                vs1 = shift_amounts(sew);
                vs2 = vs2 | (sel & sign_bits(sew));  // Negative elements
            end
            3: begin
                if ($urandom_range(3, 0) == 0) begin
                    op = vop_e'($urandom_range(VMERGE, VADD));  // Other ops between multiplies
                end else begin
                    op = vop_e'($urandom_range(VMULHU, VMUL));
                end
            end
            4: begin
                idx = $urandom_range(6, 0);
                op  = (idx == 6) ? VNOP : vop_e'(int'(VAND) + idx);
            end
            default: op = vop_e'($urandom_range(VMERGE, VNOP));
        endcase
        drive(op, sew, vs1, vs2);
    endtask

    task automatic run_test(string name, int id, int n);
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        for (int k = 0; k < n; k++) begin
            issue_one(id);
            if (id == 5) begin
                idle($urandom_range(MAX_GAP, 0));
                if (k == n / 2) begin
                    apply_reset();  // Mid-run reset with work in flight
                end
            end
        end
        idle(1);
        do begin
            @(negedge clk_i);
        end while (pending != 0);
        $display("test %s: %0d issued, %0d checked, %0d errors",
                 name, n, checks - c0, errors - e0);
    endtask

    initial begin
        void'($urandom(83));
        clk_i      = 1'b0;
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        instr_i    = '{op: VNOP, sew: SEW_8};
        data_vs1_i = '0;
        data_vs2_i = '0;
        repeat (RST_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        run_test("arith", 0, N_ARITH);
        run_test("compare", 1, N_OTHER);
        run_test("shift", 2, N_OTHER);
        run_test("multiply", 3, N_OTHER);
        run_test("logic_id_move", 4, N_LOGIC);
        run_test("gaps_reset", 5, N_OTHER);
        if (pending != 0) begin
            $display("error: %0d expected results never came out", pending);
        end
        failed = errors + simd_lane_top_inst.simd_lane_asserts_inst.failures + pending;
        $display("summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                 simd_lane_top_inst.simd_lane_asserts_inst.failures);
        if (failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== simd_lane_top.f ====
source/simd_pkg.sv
source/lane_ctrl.sv
source/vaddsub.sv
source/vcomp.sv
source/vshift.sv
source/vmul.sv
source/functional_unit.sv
source/simd_lane_top.sv
verification/simd_lane_asserts.sv
verification/simd_lane_checker.sv
verification/simd_lane_tb.sv
